// ==== filelist.f ====
verilog/conv_pkg.sv
verilog/bf16_mult.sv
verilog/bf16_add_tree.sv
verilog/kernel_regs.sv
verilog/frame_decode.sv
verilog/conv_execute.sv
verilog/conv_result.sv
verilog/conv_top.sv
sim/conv_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vconv_tb

all: run

$(SIM): filelist.f verilog/*.sv sim/conv_tb.sv
	verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f filelist.f -o Vconv_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== sim/conv_tb.sv ====
`timescale 1ns/1ps

module conv_tb;
    import conv_pkg::*;

    localparam int LINE_WIDTH = 8;
    localparam int KX = 3;
    localparam int KY = 3;
    localparam int TOTAL_BEATS = 4 * (2 + 48) + (2 + 30) + 12; // frames plus bus cycles.
    localparam int CYCLE_LIMIT = 40 * TOTAL_BEATS;
    localparam int READY_HIGH = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW = 2;

    logic        clock;
    logic        clock_sreset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    pix_beat_t   in_beat;
    logic        in_valid;
    logic        in_ready;
    res_beat_t   out_beat;
    logic        out_valid;
    logic        out_ready;

    int          seed = 32'h85ab;
    int          ready_seed = 32'h85ab; // separate stream for out_ready.
    int          ready_mode = READY_HIGH;
    int          errors = 0;
    int          results = 0;
    int          bus_cycles = 0;
    int          cycle_count = 0;
    int          kern [KX*KY]; // write order.
    int          img [16][16]; // [y][x].
    res_beat_t   exp_q [$];
    res_beat_t   exp_beat;

    conv_top #(
        .LINE_WIDTH(LINE_WIDTH),
        .KX(KX),
        .KY(KY)
    ) UUT (
        .clock(clock),
        .clock_sreset(clock_sreset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_beat(out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clock);
            case (ready_mode)
                READY_RANDOM: out_ready = $random(ready_seed) & 1;
                READY_LOW:    out_ready = 1'b0;
                default:      out_ready = 1'b1;
            endcase
        end
    end

    // ##########################################################################
    // reference model
    // ##########################################################################

    function automatic bf16_t to_bf16(input int value);
        bf16_t r;
        int    mag;
        int    msb;

        r = '0;
        mag = (value < 0) ? -value : value;
        msb = 0;
        if (mag != 0) begin
            for (int k = 0; k < 16; k++) begin
                if ((mag >> k) & 1) begin
                    msb = k;
                end
            end
            r.sign = (value < 0);
            r.exp = 8'(127 + msb);
            r.mant = 7'((mag << 7) >> msb); // hidden bit drops out.
        end
        return r;
    endfunction

    function automatic int window_sum(input int x, input int y);
        int acc;

        acc = 0;
        for (int j = 0; j < KY; j++) begin
            for (int i = 0; i < KX; i++) begin
                acc += img[y-j][x-i] * kern[KX*KY-1-(j*KX+i)];
            end
        end
        return acc;
    endfunction

    // ##########################################################################
    // bus and stream drivers, all called right after a falling edge
    // ##########################################################################

    task automatic wb_transfer(input logic we, input logic adr, input logic [15:0] dat,
                               output logic [15:0] rdata);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
        @(negedge clock);
        while (!wb_rsp.ack) begin
            @(negedge clock);
        end
        rdata = wb_rsp.dat_r;
        wb_req = '0;
        bus_cycles++;
        @(negedge clock);
    endtask

    task automatic send_beat(input pix_beat_t beat);
        in_beat = beat;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clock);
        end
        @(negedge clock); // transferred on the edge in between.
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clock);
        ready_mode = mode;
        @(negedge clock);
    endtask

    task automatic send_frame(input int width, input int height, input int expect_n);
        pix_beat_t beat;
        int        base;

        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                img[y][x] = int'($unsigned($random(seed)) % 8);
            end
        end
        if (width == LINE_WIDTH) begin
            for (int y = KY - 1; y < height; y++) begin
                for (int x = KX - 1; x < width; x++) begin
                    exp_beat.data = to_bf16(window_sum(x, y));
                    exp_beat.sop = (x == KX - 1) && (y == KY - 1);
                    exp_beat.eop = (x == width - 1) && (y == height - 1);
                    exp_q.push_back(exp_beat);
                end
            end
        end
        base = results;
        beat = '0;
        beat.data = 16'(width);
        beat.sop = 1'b1;
        send_beat(beat);
        beat.data = 16'(height);
        beat.sop = 1'b0;
        send_beat(beat);
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                beat.data = to_bf16(img[y][x]);
                beat.eop = (x == width - 1) && (y == height - 1);
                send_beat(beat);
            end
        end
        in_valid = 1'b0;
        in_beat = '0;
        while (exp_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (20) @(negedge clock); // let any stray result show up.
        assert (results - base == expect_n) else begin
            errors++;
            $display("Error at %0t: frame %0dx%0d gave %0d results, expected %0d",
                     $time, width, height, results - base, expect_n);
        end
    endtask

    task automatic print_counts;
        $display("results %0d, bus cycles %0d, pending %0d, errors %0d",
                 results, bus_cycles, exp_q.size(), errors);
    endtask

    // ##########################################################################
    // checkers
    // ##########################################################################

    always @(posedge clock) begin
        if (!clock_sreset && out_valid && out_ready) begin
            results++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t: unexpected result %h", $time, out_beat);
            end
            else begin
                exp_beat = exp_q.pop_front();
                assert (out_beat == exp_beat) else begin
                    errors++;
                    $display("Error at %0t: result %h (sop %b eop %b), expected %h (sop %b eop %b)",
                             $time, out_beat.data, out_beat.sop, out_beat.eop,
                             exp_beat.data, exp_beat.sop, exp_beat.eop);
                end
            end
        end
    end

    assert property (@(posedge clock) $past(clock_sreset) && !clock_sreset |->
                     !in_ready && !out_valid && !wb_rsp.ack) else begin
        errors++;
        $display("Error at %0t: outputs not low in the first cycle after reset", $time);
    end

    assert property (@(posedge clock) disable iff (clock_sreset)
                     (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack) else begin
        errors++;
        $display("Error at %0t: no ack in the cycle after stb", $time);
    end

    assert property (@(posedge clock) disable iff (clock_sreset)
                     wb_rsp.ack |=> !wb_rsp.ack) else begin
        errors++;
        $display("Error at %0t: ack held longer than one cycle", $time);
    end

    assert property (@(posedge clock) disable iff (clock_sreset)
                     wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)) else begin
        errors++;
        $display("Error at %0t: ack without a request", $time);
    end

    assert property (@(posedge clock) disable iff (clock_sreset)
                     (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))) else begin
        errors++;
        $display("Error at %0t: output changed while stalled", $time);
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        print_counts();
        $display("Test failures found");
        $finish;
    end

    // ##########################################################################
    // test sequence
    // ##########################################################################

    initial begin
        logic [15:0] rdata;
        logic        stalled;

        clock_sreset = 1'b1;
        wb_req = '0;
        in_beat = '0;
        in_valid = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        clock_sreset = 1'b0;
        @(negedge clock);

        for (int k = 0; k < KX * KY; k++) begin
            kern[k] = int'($unsigned($random(seed)) % 7) - 3;
            wb_transfer(1'b1, 1'b0, to_bf16(kern[k]), rdata);
        end
        wb_transfer(1'b0, 1'b1, 16'h0000, rdata);
        assert (rdata == 16'd0) else begin
            errors++;
            $display("Error at %0t: drop count %0d, expected 0", $time, rdata);
        end
        wb_transfer(1'b0, 1'b0, 16'h0000, rdata);
        assert (rdata == 16'd0) else begin
            errors++;
            $display("Error at %0t: address 0 read %h, expected 0", $time, rdata);
        end

        send_frame(8, 6, 24);
        set_ready_mode(READY_RANDOM);
        send_frame(8, 6, 24);

        set_ready_mode(READY_LOW);
        fork
            send_frame(8, 6, 24);
            begin
                stalled = 1'b0;
                for (int k = 0; k < 200 && !stalled; k++) begin
                    @(posedge clock);
                    stalled = in_valid && !in_ready;
                end
                assert (stalled) else begin
                    errors++;
                    $display("in_ready never dropped while out_ready was held low");
                end
                repeat (10) @(posedge clock); // hold the stall a while.
                ready_mode = READY_RANDOM;
            end
        join

        send_frame(5, 6, 0); // wrong width is dropped.
        wb_transfer(1'b0, 1'b1, 16'h0000, rdata);
        assert (rdata == 16'd1) else begin
            errors++;
            $display("Error at %0t: drop count %0d, expected 1", $time, rdata);
        end
        send_frame(8, 6, 24);

        print_counts();
        if (errors == 0 && exp_q.size() == 0) begin
            $display("All tests passed!");
        end
        else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verilog/conv_top.sv ====
`timescale 1ns/1ps

module conv_top #(
    parameter int LINE_WIDTH = 8,
    parameter int KX = 3,
    parameter int KY = 3,
    parameter int MLT_LCYCLES = 1,
    parameter int RESULT_DEPTH = 16
) (
    input  logic                clock,
    input  logic                clock_sreset,
    input  conv_pkg::wb_req_t   wb_req,
    output conv_pkg::wb_rsp_t   wb_rsp,
    input  conv_pkg::pix_beat_t in_beat,
    input  logic                in_valid,
    output logic                in_ready,
    output conv_pkg::res_beat_t out_beat,
    output logic                out_valid,
    input  logic                out_ready
);
    import conv_pkg::*;

    localparam int PIPE_DEPTH = 1 + MLT_LCYCLES + $clog2(KX * KY);

    bf16_t [KX*KY-1:0] kernel;
    bf16_t             pixel;
    bf16_t             sum;
    logic              shift_en;
    logic              calc_valid;
    logic              calc_first;
    logic              calc_last;
    logic              drop_pulse;
    logic              accept_ok;
    logic              sum_valid;
    logic              sum_first;
    logic              sum_last;

    kernel_regs #(
        .KX(KX),
        .KY(KY)
    ) u_kernel (
        .clock(clock),
        .clock_sreset(clock_sreset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .drop_pulse(drop_pulse),
        .kernel(kernel)
    );

    frame_decode #(
        .LINE_WIDTH(LINE_WIDTH),
        .KX(KX),
        .KY(KY)
    ) u_decode (
        .clock(clock),
        .clock_sreset(clock_sreset),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .accept_ok(accept_ok),
        .in_ready(in_ready),
        .shift_en(shift_en),
        .pixel(pixel),
        .calc_valid(calc_valid),
        .calc_first(calc_first),
        .calc_last(calc_last),
        .drop_pulse(drop_pulse)
    );

    conv_execute #(
        .LINE_WIDTH(LINE_WIDTH),
        .KX(KX),
        .KY(KY),
        .MLT_LCYCLES(MLT_LCYCLES)
    ) u_execute (
        .clock(clock),
        .clock_sreset(clock_sreset),
        .shift_en(shift_en),
        .pixel(pixel),
        .calc_valid(calc_valid),
        .calc_first(calc_first),
        .calc_last(calc_last),
        .kernel(kernel),
        .sum(sum),
        .sum_valid(sum_valid),
        .sum_first(sum_first),
        .sum_last(sum_last)
    );

    // calc_valid is already qualified by an accepted pixel.
    conv_result #(
        .RESULT_DEPTH(RESULT_DEPTH),
        .PIPE_DEPTH(PIPE_DEPTH)
    ) u_result (
        .clock(clock),
        .clock_sreset(clock_sreset),
        .sum(sum),
        .sum_valid(sum_valid),
        .sum_first(sum_first),
        .sum_last(sum_last),
        .shift_calc(calc_valid),
        .accept_ok(accept_ok),
        .out_beat(out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// ==== verilog/conv_result.sv ====
`timescale 1ns/1ps

module conv_result #(
    parameter int RESULT_DEPTH = 16,
    parameter int PIPE_DEPTH = 6
) (
    input  logic                clock,
    input  logic                clock_sreset,
    input  conv_pkg::bf16_t     sum,
    input  logic                sum_valid,
    input  logic                sum_first,
    input  logic                sum_last,
    input  logic                shift_calc,
    output logic                accept_ok,
    output conv_pkg::res_beat_t out_beat,
    output logic                out_valid,
    input  logic                out_ready
);
    import conv_pkg::*;

    localparam int PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
    localparam int CNT_W = $clog2(RESULT_DEPTH + 1);
    localparam int IFL_W = $clog2(PIPE_DEPTH + 2);

    res_beat_t        mem [RESULT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_cnt;
    logic [IFL_W-1:0] in_flight;
    logic             ready_en;
    logic             pop;

    assign out_valid = (count != '0);
    assign out_beat = mem[rd_ptr];
    assign pop = out_valid && out_ready;
    assign free_cnt = CNT_W'(RESULT_DEPTH) - count;
    assign accept_ok = ready_en && (32'(free_cnt) > 32'(in_flight)); // room for all in flight.

    always_ff @(posedge clock) begin
        if (sum_valid) begin
            mem[wr_ptr] <= '{data: sum, sop: sum_first, eop: sum_last};
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_flight <= '0;
            ready_en <= 1'b0;
        end
        else begin
            ready_en <= 1'b1; // low for the first cycle.
            if (sum_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({sum_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({shift_calc, sum_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

endmodule

// ==== verilog/conv_execute.sv ====
`timescale 1ns/1ps

module conv_execute #(
    parameter int LINE_WIDTH = 8,
    parameter int KX = 3,
    parameter int KY = 3,
    parameter int MLT_LCYCLES = 1
) (
    input  logic                        clock,
    input  logic                        clock_sreset,
    input  logic                        shift_en,
    input  conv_pkg::bf16_t             pixel,
    input  logic                        calc_valid,
    input  logic                        calc_first,
    input  logic                        calc_last,
    input  conv_pkg::bf16_t [KX*KY-1:0] kernel,
    output conv_pkg::bf16_t             sum,
    output logic                        sum_valid,
    output logic                        sum_first,
    output logic                        sum_last
);
    import conv_pkg::*;

    localparam int TAPS = KX * KY;
    localparam int TREE_LEVELS = $clog2(TAPS);
    localparam int FLAG_DEPTH = 1 + MLT_LCYCLES + TREE_LEVELS;
    localparam int WIN_LEN = (KY - 1) * LINE_WIDTH + KX; // last tap is (KX-1, KY-1).

    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } flags_t;

    bf16_t              win [WIN_LEN];
    bf16_t [TAPS-1:0]   products;
    flags_t             flags [FLAG_DEPTH];

    // win[j*LINE_WIDTH + i] holds the pixel at (x-i, y-j).
    always_ff @(posedge clock) begin
        if (shift_en) begin
            win[0] <= pixel;
            for (int k = 1; k < WIN_LEN; k++) begin
                win[k] <= win[k-1];
            end
        end
    end

    for (genvar j = 0; j < KY; j++) begin : g_row
        for (genvar i = 0; i < KX; i++) begin : g_col
            bf16_mult #(
                .LCYCLES(MLT_LCYCLES)
            ) u_mult (
                .clock(clock),
                .clock_sreset(clock_sreset),
                .dataa(win[j*LINE_WIDTH+i]),
                .datab(kernel[j*KX+i]),
                .result(products[j*KX+i])
            );
        end
    end

    bf16_add_tree #(
        .ITEMS(TAPS)
    ) u_tree (
        .clock(clock),
        .clock_sreset(clock_sreset),
        .items(products),
        .result(sum)
    );

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            flags <= '{default: '0};
        end
        else begin
            flags[0] <= '{valid: calc_valid, first: calc_first, last: calc_last};
            for (int k = 1; k < FLAG_DEPTH; k++) begin
                flags[k] <= flags[k-1];
            end
        end
    end

    assign sum_valid = flags[FLAG_DEPTH-1].valid;
    assign sum_first = flags[FLAG_DEPTH-1].first;
    assign sum_last = flags[FLAG_DEPTH-1].last;

endmodule

// ==== verilog/frame_decode.sv ====
`timescale 1ns/1ps

module frame_decode #(
    parameter int LINE_WIDTH = 8,
    parameter int KX = 3,
    parameter int KY = 3
) (
    input  logic                clock,
    input  logic                clock_sreset,
    input  conv_pkg::pix_beat_t in_beat,
    input  logic                in_valid,
    input  logic                accept_ok,
    output logic                in_ready,
    output logic                shift_en,
    output conv_pkg::bf16_t     pixel,
    output logic                calc_valid,
    output logic                calc_first,
    output logic                calc_last,
    output logic                drop_pulse
);
    import conv_pkg::*;

    decode_state_e    state;
    logic [DIM_W-1:0] x;
    logic [DIM_W-1:0] y;
    logic [DIM_W-1:0] height;
    logic [DIM_W-1:0] field;
    logic             accepted;
    logic             line_end;
    logic             frame_end;

    assign in_ready = (state == DROP) || accept_ok; // drain rejected frames.
    assign accepted = in_valid && in_ready;
    assign field = in_beat.data[DIM_W-1:0];
    assign pixel = in_beat.data;
    assign shift_en = accepted && (state == PIXELS);

    assign line_end = (x == DIM_W'(LINE_WIDTH - 1));
    assign frame_end = line_end && (y == height - 1'b1);
    assign calc_valid = shift_en && (x >= DIM_W'(KX - 1)) && (y >= DIM_W'(KY - 1));
    assign calc_first = calc_valid && (x == DIM_W'(KX - 1)) && (y == DIM_W'(KY - 1));
    assign calc_last = calc_valid && frame_end;
    assign drop_pulse = accepted && (state == HEADER_WIDTH) && in_beat.sop &&
                        (field != DIM_W'(LINE_WIDTH));

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= HEADER_WIDTH;
            x <= '0;
            y <= '0;
        end
        else begin
            case (state)
                HEADER_WIDTH: begin
                    if (accepted && in_beat.sop) begin
                        state <= drop_pulse ? DROP : HEADER_HEIGHT;
                    end
                end
                HEADER_HEIGHT: begin
                    if (accepted) begin
                        x <= '0;
                        y <= '0;
                        state <= PIXELS;
                    end
                end
                PIXELS: begin
                    if (shift_en) begin
                        if (line_end) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end
                        else begin
                            x <= x + 1'b1;
                        end
                        if (in_beat.eop || frame_end) begin
                            state <= HEADER_WIDTH;
                        end
                    end
                end
                DROP: begin
                    if (accepted && in_beat.eop) begin
                        state <= HEADER_WIDTH;
                    end
                end
                default: state <= HEADER_WIDTH;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accepted && state == HEADER_HEIGHT) begin
            height <= field;
        end
    end

endmodule

// ==== verilog/kernel_regs.sv ====
`timescale 1ns/1ps

module kernel_regs #(
    parameter int KX = 3,
    parameter int KY = 3
) (
    input  logic                        clock,
    input  logic                        clock_sreset,
    input  conv_pkg::wb_req_t           wb_req,
    output conv_pkg::wb_rsp_t           wb_rsp,
    input  logic                        drop_pulse,
    output conv_pkg::bf16_t [KX*KY-1:0] kernel
);
    logic        ack;
    logic        access;
    logic [15:0] dat_r;
    logic [15:0] drop_count;

    assign access = wb_req.cyc && wb_req.stb && !ack; // one ack per cycle.
    assign wb_rsp = '{ack: ack, dat_r: dat_r};

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            ack <= 1'b0;
            drop_count <= '0;
        end
        else begin
            ack <= access;
            if (drop_pulse && drop_count != 16'hffff) begin
                drop_count <= drop_count + 16'd1; // saturates.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            dat_r <= wb_req.adr ? drop_count : 16'h0000;
        end
        if (access && wb_req.we && !wb_req.adr) begin
            kernel[0] <= wb_req.dat_w; // oldest word drifts deepest.
            for (int k = 1; k < KX * KY; k++) begin
                kernel[k] <= kernel[k-1];
            end
        end
    end

endmodule

// ==== verilog/bf16_add_tree.sv ====
`timescale 1ns/1ps

module bf16_add_tree #(
    parameter int ITEMS = 9
) (
    input  logic                        clock,
    input  logic                        clock_sreset,
    input  conv_pkg::bf16_t [ITEMS-1:0] items,
    output conv_pkg::bf16_t             result
);
    import conv_pkg::*;

    localparam int LEVELS = $clog2(ITEMS);

    function automatic int level_count(int lvl);
        int n;
        n = ITEMS;
        for (int k = 0; k < lvl; k++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    // ##########################################################################
    // single adder, align / add / renormalize / truncate
    // ##########################################################################

    function automatic bf16_t bf16_add(bf16_t a, bf16_t b);
        bf16_t       op_hi;
        bf16_t       op_lo;
        bf16_t       res;
        logic [7:0]  diff;
        logic [11:0] sig_hi;
        logic [11:0] sig_lo;
        logic [11:0] sig_sum;
        int          lz;

        lz = 0;
        if ({a.exp, a.mant} >= {b.exp, b.mant}) begin
            op_hi = a;
            op_lo = b;
        end
        else begin
            op_hi = b;
            op_lo = a;
        end
        diff = op_hi.exp - op_lo.exp;
        sig_hi = {2'b01, op_hi.mant, 3'b000}; // carry, hidden, mantissa, guard.
        sig_lo = (op_lo.exp == 8'd0) ? '0 : ({2'b01, op_lo.mant, 3'b000} >> diff);
        if (op_hi.sign == op_lo.sign) begin
            sig_sum = sig_hi + sig_lo;
        end
        else begin
            sig_sum = sig_hi - sig_lo; // never negative.
        end
        for (int k = 0; k < 11; k++) begin
            if (sig_sum[k]) begin
                lz = 10 - k;
            end
        end
        if (op_hi.exp == 8'd0 || sig_sum == '0) begin
            res = '0; // both zero or exact cancellation.
        end
        else if (sig_sum[11]) begin
            res = '{sign: op_hi.sign, exp: op_hi.exp + 8'd1, mant: sig_sum[10:4]};
        end
        else if (int'(op_hi.exp) <= lz) begin
            res = '0;
        end
        else begin
            sig_sum = sig_sum << lz;
            res = '{sign: op_hi.sign, exp: op_hi.exp - 8'(lz), mant: sig_sum[9:3]};
        end
        return res;
    endfunction

    // ##########################################################################
    // registered reduction levels
    // ##########################################################################

    for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
        localparam int N_IN = level_count(l);
        localparam int N_OUT = level_count(l + 1);
        bf16_t d   [N_IN];
        bf16_t nxt [N_OUT];
        bf16_t q   [N_OUT];

        if (l == 0) begin : g_first
            for (genvar k = 0; k < N_IN; k++) begin : g_in
                assign d[k] = items[k];
            end
        end
        else begin : g_next
            assign d = g_lvl[l-1].q;
        end

        for (genvar k = 0; k < N_OUT; k++) begin : g_node
            if (2 * k + 1 < N_IN) begin : g_add
                assign nxt[k] = bf16_add(d[2*k], d[2*k+1]);
            end
            else begin : g_pass
                assign nxt[k] = d[2*k]; // odd item.
            end
        end

        always_ff @(posedge clock) begin
            if (clock_sreset) begin
                q <= '{default: '0};
            end
            else begin
                q <= nxt;
            end
        end
    end

    if (LEVELS == 0) begin : g_single
        assign result = items[0];
    end
    else begin : g_root
        assign result = g_lvl[LEVELS-1].q[0];
    end

endmodule

// ==== verilog/bf16_mult.sv ====
`timescale 1ns/1ps

module bf16_mult #(
    parameter int LCYCLES = 1
) (
    input  logic            clock,
    input  logic            clock_sreset,
    input  conv_pkg::bf16_t dataa,
    input  conv_pkg::bf16_t datab,
    output conv_pkg::bf16_t result
);
    import conv_pkg::*;

    logic [15:0] sig_prod;
    logic [9:0]  exp_sum;
    bf16_t       product;
    bf16_t       pipe [LCYCLES];

    always_comb begin
        sig_prod = {1'b1, dataa.mant} * {1'b1, datab.mant};
        exp_sum = 10'(dataa.exp) + 10'(datab.exp) + 10'(sig_prod[15]); // biased twice.
        product.sign = dataa.sign ^ datab.sign;
        product.exp = 8'(exp_sum - 10'd127);
        product.mant = sig_prod[15] ? sig_prod[14:8] : sig_prod[13:7]; // truncate.
        if (dataa.exp == 8'd0 || datab.exp == 8'd0 || exp_sum <= 10'd127) begin
            product = '0; // zero operand or underflow.
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            pipe <= '{default: '0};
        end
        else begin
            pipe[0] <= product;
            for (int k = 1; k < LCYCLES; k++) begin
                pipe[k] <= pipe[k-1];
            end
        end
    end

    assign result = pipe[LCYCLES-1];

endmodule

// ==== verilog/conv_pkg.sv ====
package conv_pkg;

    localparam int DIM_W = 12; // header dimension field.

    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [6:0] mant;
    } bf16_t;

    typedef struct packed {
        bf16_t data;
        logic  sop;
        logic  eop;
    } pix_beat_t;

    typedef struct packed {
        bf16_t data;
        logic  sop; // first result of a frame.
        logic  eop; // last result of a frame.
    } res_beat_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic        adr;
        logic [15:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat_r;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        HEADER_WIDTH,
        HEADER_HEIGHT,
        PIXELS,
        DROP
    } decode_state_e;

endpackage
